/* fft_top.f */
source/fft_pkg.sv
source/complex_multiplier.sv
source/butterfly.sv
source/sample_buffer.sv
source/fft_config.sv
source/fft_control.sv
source/fft_top.sv
verification/fft_chk.sv
verification/fft_tb.sv

/* Bender.yml */
package:
  name: fft_top

sources:
  # rtl in compile order
  - files:
      - source/fft_pkg.sv
      - source/complex_multiplier.sv
      - source/butterfly.sv
      - source/sample_buffer.sv
      - source/fft_config.sv
      - source/fft_control.sv
      - source/fft_top.sv

  # bound checker and testbench
  - target: simulation
    files:
      - verification/fft_chk.sv
      - verification/fft_tb.sv

/* verification/fft_tb.sv */
// ==========================================================================
// fft testbench
// drives frames into fft_top, checks every output word against a
// bit-exact reference FFT model, with a cycle-count watchdog
// ==========================================================================

module fft_tb import fft_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // 24 frames of at most 250 cycles each
  localparam int max_cycles = 24 * 250;

  logic        clk;
  logic        reset;
  logic        cfg_wr;
  stage_mask_t cfg_scale;
  logic        cfg_inverse;
  logic        start;
  logic        in_valid;
  data_t       in_re;
  data_t       in_im;
  logic        busy;
  logic        out_valid;
  addr_t       out_index;
  data_t       out_re;
  data_t       out_im;
  logic        done;

  // frame input, model result, captured DUT output, saved input
  data_t stim_re [N_POINTS];
  data_t stim_im [N_POINTS];
  data_t exp_re [N_POINTS];
  data_t exp_im [N_POINTS];
  data_t got_re [N_POINTS];
  data_t got_im [N_POINTS];
  data_t orig_re [N_POINTS];
  data_t orig_im [N_POINTS];

  integer seed = 32'h00b1_28f8;
  int     out_count = 0;
  int     frames_seen = 0;
  int     frames_run = 0;
  int     cycles = 0;
  int     diff;

  fft_top fft_top_inst (
    .clk         (clk),
    .reset       (reset),
    .cfg_wr      (cfg_wr),
    .cfg_scale   (cfg_scale),
    .cfg_inverse (cfg_inverse),
    .start       (start),
    .in_valid    (in_valid),
    .in_re       (in_re),
    .in_im       (in_im),
    .busy        (busy),
    .out_valid   (out_valid),
    .out_index   (out_index),
    .out_re      (out_re),
    .out_im      (out_im),
    .done        (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ========================================================================
  // reference model
  // ========================================================================

  function automatic int bit_reverse(input int i);
    return ((i & 1) << 2) | (i & 2) | ((i >> 2) & 1);
  endfunction

  // 17-bit sum, optional floor halving, wrap to 16 bits
  function automatic data_t wrap_sum(input int a, input int b, input logic halve);
    int s;
    s = a + b;
    if (halve) begin
      s = s >>> 1;
    end
    return data_t'(s);
  endfunction

  // fills exp_re/exp_im from stim_re/stim_im
  function automatic void fft_model(input stage_mask_t mask, input logic inv);
    data_t  xr [N_POINTS];
    data_t  xi [N_POINTS];
    int     span;
    int     low;
    int     top;
    int     bot;
    int     k;
    longint wr;
    longint wi;
    longint p_re;
    longint p_im;
    data_t  tr;
    data_t  ti;
    data_t  ar;
    data_t  ai;
    for (int i = 0; i < N_POINTS; i++) begin
      xr[bit_reverse(i)] = stim_re[i];
      xi[bit_reverse(i)] = stim_im[i];
    end
    for (int s = 0; s < LOG2_N; s++) begin
      for (int j = 0; j < N_POINTS / 2; j++) begin
        span = 1 << s;
        low  = j % span;
        top  = (j >> s) * 2 * span + low;
        bot  = top + span;
        k    = low << (LOG2_N - 1 - s);
        // forward W8^k table
        case (k)
          0: begin
            wr = TW_ONE;
            wi = 0;
          end
          1: begin
            wr = TW_HALF_SQRT2;
            wi = -TW_HALF_SQRT2;
          end
          2: begin
            wr = 0;
            wi = -TW_ONE;
          end
          default: begin
            wr = -TW_HALF_SQRT2;
            wi = -TW_HALF_SQRT2;
          end
        endcase
        if (inv) begin
          wi = -wi;
        end
        // full width product then floor shift by the fraction bits
        p_re = longint'(xr[bot]) * wr - longint'(xi[bot]) * wi;
        p_im = longint'(xr[bot]) * wi + longint'(xi[bot]) * wr;
        tr   = data_t'(p_re >>> FRAC_W);
        ti   = data_t'(p_im >>> FRAC_W);
        ar   = xr[top];
        ai   = xi[top];
        xr[top] = wrap_sum(ar, tr, mask[s]);
        xi[top] = wrap_sum(ai, ti, mask[s]);
        xr[bot] = wrap_sum(ar, -int'(tr), mask[s]);
        xi[bot] = wrap_sum(ai, -int'(ti), mask[s]);
      end
    end
    for (int i = 0; i < N_POINTS; i++) begin
      exp_re[i] = xr[i];
      exp_im[i] = xi[i];
    end
  endfunction

  // ========================================================================
  // checks and stimulus tasks
  // ========================================================================

  task automatic check_value(input string what, input logic signed [31:0] got,
                             input logic signed [31:0] want);
    if (got !== want) begin
      $display("error: t=%0d ns: %s mismatch, got %0d expected %0d",
               $time, what, got, want);
      $display("Testbench failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic write_config(input stage_mask_t mask, input logic inv);
    cfg_scale   = mask;
    cfg_inverse = inv;
    cfg_wr      = 1'b1;
    next_cycle();
    cfg_wr      = 1'b0;
  endtask

  task automatic start_frame();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    check_value("busy after start", busy, 1);
  endtask

  // eight samples with 0..max_gap idle cycles before each
  task automatic load_frame(input int max_gap);
    int gap;
    for (int i = 0; i < N_POINTS; i++) begin
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) next_cycle();
      in_valid = 1'b1;
      in_re    = stim_re[i];
      in_im    = stim_im[i];
      next_cycle();
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_frame();
    frames_run++;
    wait (frames_seen == frames_run);
    next_cycle();
    check_value("busy after done", busy, 0);
  endtask

  task automatic run_frame(input stage_mask_t mask, input logic inv, input int max_gap);
    fft_model(mask, inv);
    start_frame();
    load_frame(max_gap);
    wait_frame();
  endtask

  // limit 0 means full 16-bit range
  task automatic fill_random(input int limit);
    for (int i = 0; i < N_POINTS; i++) begin
      stim_re[i] = (limit == 0) ? data_t'($random(seed)) : data_t'($random(seed) % limit);
      stim_im[i] = (limit == 0) ? data_t'($random(seed)) : data_t'($random(seed) % limit);
    end
  endtask

  // ========================================================================
  // compare process and watchdog
  // ========================================================================

  // sampled mid-cycle where the registered outputs are settled
  initial begin : compare
    forever begin
      @(negedge clk);
      check_value("assertion failures", fft_top_inst.u_chk.fail_count, 0);
      if (out_valid) begin
        check_value("out_index", out_index, out_count);
        check_value("out_re", out_re, exp_re[out_index]);
        check_value("out_im", out_im, exp_im[out_index]);
        check_value("done on last word", done, out_count == N_POINTS - 1);
        got_re[out_index] = out_re;
        got_im[out_index] = out_im;
        if (out_count == N_POINTS - 1) begin
          out_count = 0;
          frames_seen++;
        end else begin
          out_count++;
        end
      end else begin
        check_value("done without out_valid", done, 0);
      end
    end
  end

  initial begin : watchdog
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no result after %0d clock cycles", max_cycles);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  // ========================================================================
  // test sequence
  // ========================================================================

  initial begin : main
    reset       = 1'b1;
    cfg_wr      = 1'b0;
    cfg_scale   = '0;
    cfg_inverse = 1'b0;
    start       = 1'b0;
    in_valid    = 1'b0;
    in_re       = '0;
    in_im       = '0;
    repeat (10) @(posedge clk);
    #10;
    reset = 1'b0;

    // idle after reset, then one frame on the reset config
    repeat (3) begin
      @(negedge clk);
      check_value("busy after reset", busy, 0);
      check_value("out_valid after reset", out_valid, 0);
      check_value("done after reset", done, 0);
    end
    next_cycle();
    fill_random(0);
    run_frame('0, 1'b0, 0);

    // impulse gives a flat spectrum
    for (int i = 0; i < N_POINTS; i++) begin
      stim_re[i] = '0;
      stim_im[i] = '0;
    end
    stim_re[0] = 16'sd8192;
    run_frame('0, 1'b0, 1);
    for (int i = 0; i < N_POINTS; i++) begin
      check_value("impulse re", got_re[i], 8192);
      check_value("impulse im", got_im[i], 0);
    end

    // constant lands in bin 0 only
    for (int i = 0; i < N_POINTS; i++) begin
      stim_re[i] = 16'sd1000;
      stim_im[i] = -16'sd500;
    end
    run_frame('0, 1'b0, 0);
    check_value("constant bin 0 re", got_re[0], 8000);
    check_value("constant bin 0 im", got_im[0], -4000);
    for (int i = 1; i < N_POINTS; i++) begin
      check_value("constant other bin re", got_re[i], 0);
      check_value("constant other bin im", got_im[i], 0);
    end

    // random frames with random settings and strobe spacing
    for (int f = 0; f < 16; f++) begin
      cfg_scale   = stage_mask_t'($random(seed));
      cfg_inverse = $random(seed) & 1;
      write_config(cfg_scale, cfg_inverse);
      fill_random(0);
      run_frame(cfg_scale, cfg_inverse, f % 4);
    end

    // forward then inverse with 1/8 scaling each returns x/8
    write_config(3'b111, 1'b0);
    fill_random(4096);
    orig_re = stim_re;
    orig_im = stim_im;
    run_frame(3'b111, 1'b0, 1);
    stim_re = got_re;
    stim_im = got_im;
    write_config(3'b111, 1'b1);
    run_frame(3'b111, 1'b1, 0);
    for (int i = 0; i < N_POINTS; i++) begin
      diff = 8 * int'(got_re[i]) - int'(orig_re[i]);
      check_value("round trip re within 12 lsb", diff <= 96 && diff >= -96, 1);
      diff = 8 * int'(got_im[i]) - int'(orig_im[i]);
      check_value("round trip im within 12 lsb", diff <= 96 && diff >= -96, 1);
    end

    // config write during a frame is dropped
    write_config(3'b101, 1'b0);
    fill_random(0);
    fft_model(3'b101, 1'b0);
    start_frame();
    write_config(3'b010, 1'b1);
    load_frame(2);
    wait_frame();
    fill_random(0);
    run_frame(3'b101, 1'b0, 2);

    if (fft_top_inst.u_chk.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verification/fft_chk.sv */
// ==========================================================================
// fft strobe checker
// concurrent assertions on busy, out_valid and done, bound into fft_top
// ==========================================================================

module fft_chk import fft_pkg::*; (
  input logic clk,
  input logic reset,
  input logic busy,
  input logic out_valid,
  input logic done
);

  timeunit 1ns;
  timeprecision 1ps;

  // number of assertion failures, read by the testbench at the end
  int fail_count = 0;

  // done only marks the last output word
  a_done_with_valid: assert property (@(posedge clk) disable iff (reset)
    done |-> out_valid)
    else begin
      fail_count++;
      $error("done high without out_valid");
    end

  // output only streams inside a frame
  a_valid_while_busy: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> busy)
    else begin
      fail_count++;
      $error("out_valid high while not busy");
    end

  // one unbroken burst of eight words per frame
  a_burst_of_eight: assert property (@(posedge clk) disable iff (reset)
    $rose(out_valid) |-> out_valid [*N_POINTS] ##1 !out_valid)
    else begin
      fail_count++;
      $error("output burst is not eight consecutive cycles");
    end

endmodule

bind fft_top fft_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .busy      (busy),
  .out_valid (out_valid),
  .done      (done)
);

/* source/fft_top.sv */
// ==========================================================================
// fft top level
// 8-point iterative FFT: config block, frame controller, sample buffer
// and one shared butterfly
// ==========================================================================

module fft_top import fft_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        cfg_wr,
  input  stage_mask_t cfg_scale,
  input  logic        cfg_inverse,
  input  logic        start,
  input  logic        in_valid,
  input  data_t       in_re,
  input  data_t       in_im,
  output logic        busy,
  output logic        out_valid,
  output addr_t       out_index,
  output data_t       out_re,
  output data_t       out_im,
  output logic        done
);

  stage_mask_t scale_mask;
  logic        inverse;

  // buffer load and address lines
  logic  ld_en;
  addr_t ld_addr;
  data_t ld_re;
  data_t ld_im;
  addr_t rd_a_addr;
  addr_t rd_b_addr;
  data_t rd_a_re;
  data_t rd_a_im;
  data_t rd_b_re;
  data_t rd_b_im;

  // write-back
  logic  wb_en;
  addr_t wb_a_addr;
  addr_t wb_b_addr;
  data_t wb_a_re;
  data_t wb_a_im;
  data_t wb_b_re;
  data_t wb_b_im;

  // butterfly handshake and twiddle
  logic  bf_recv_val;
  logic  bf_recv_rdy;
  logic  bf_send_val;
  data_t bf_wr;
  data_t bf_wi;
  logic  bf_scale;

  fft_config u_config (
    .clk         (clk),
    .reset       (reset),
    .cfg_wr      (cfg_wr),
    .cfg_scale   (cfg_scale),
    .cfg_inverse (cfg_inverse),
    .busy        (busy),
    .scale_mask  (scale_mask),
    .inverse     (inverse)
  );

  fft_control u_control (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .in_valid    (in_valid),
    .in_re       (in_re),
    .in_im       (in_im),
    .scale_mask  (scale_mask),
    .inverse     (inverse),
    .busy        (busy),
    .ld_en       (ld_en),
    .ld_addr     (ld_addr),
    .ld_re       (ld_re),
    .ld_im       (ld_im),
    .rd_a_addr   (rd_a_addr),
    .rd_b_addr   (rd_b_addr),
    .wb_en       (wb_en),
    .wb_a_addr   (wb_a_addr),
    .wb_b_addr   (wb_b_addr),
    .bf_recv_val (bf_recv_val),
    .bf_recv_rdy (bf_recv_rdy),
    .bf_send_val (bf_send_val),
    .bf_wr       (bf_wr),
    .bf_wi       (bf_wi),
    .bf_scale    (bf_scale),
    .out_valid   (out_valid),
    .out_index   (out_index),
    .done        (done)
  );

  sample_buffer u_buffer (
    .clk       (clk),
    .reset     (reset),
    .ld_en     (ld_en),
    .ld_addr   (ld_addr),
    .ld_re     (ld_re),
    .ld_im     (ld_im),
    .rd_a_addr (rd_a_addr),
    .rd_b_addr (rd_b_addr),
    .rd_a_re   (rd_a_re),
    .rd_a_im   (rd_a_im),
    .rd_b_re   (rd_b_re),
    .rd_b_im   (rd_b_im),
    .wb_en     (wb_en),
    .wb_a_addr (wb_a_addr),
    .wb_b_addr (wb_b_addr),
    .wb_a_re   (wb_a_re),
    .wb_a_im   (wb_a_im),
    .wb_b_re   (wb_b_re),
    .wb_b_im   (wb_b_im)
  );

  // operands straight from the read ports, c back to top, d to bottom
  butterfly u_butterfly (
    .clk      (clk),
    .reset    (reset),
    .recv_val (bf_recv_val),
    .recv_rdy (bf_recv_rdy),
    .ar       (rd_a_re),
    .ai       (rd_a_im),
    .br       (rd_b_re),
    .bi       (rd_b_im),
    .wr       (bf_wr),
    .wi       (bf_wi),
    .scale    (bf_scale),
    .send_val (bf_send_val),
    .cr       (wb_a_re),
    .ci       (wb_a_im),
    .dr       (wb_b_re),
    .di       (wb_b_im)
  );

  // output stream comes off read port a
  assign out_re = rd_a_re;
  assign out_im = rd_a_im;

endmodule

/* source/fft_control.sv */
// ==========================================================================
// fft controller
// frame FSM: bit-reversed load, 3 stages x 4 butterflies issued one at a
// time with twiddle lookup, then natural-order unload
// ==========================================================================

module fft_control import fft_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic        in_valid,
  input  data_t       in_re,
  input  data_t       in_im,
  input  stage_mask_t scale_mask,
  input  logic        inverse,
  output logic        busy,
  output logic        ld_en,
  output addr_t       ld_addr,
  output data_t       ld_re,
  output data_t       ld_im,
  output addr_t       rd_a_addr,
  output addr_t       rd_b_addr,
  output logic        wb_en,
  output addr_t       wb_a_addr,
  output addr_t       wb_b_addr,
  output logic        bf_recv_val,
  input  logic        bf_recv_rdy,
  input  logic        bf_send_val,
  output data_t       bf_wr,
  output data_t       bf_wi,
  output logic        bf_scale,
  output logic        out_valid,
  output addr_t       out_index,
  output logic        done
);

  ctrl_state_t state;

  // sample counter for load and unload
  addr_t       cnt;
  logic [1:0]  stage;
  logic [1:0]  bfly;
  stage_mask_t scale_q;
  logic        inv_q;

  logic         last_cnt;
  logic         last_bfly;
  addr_t        span;
  addr_t        low;
  addr_t        top;
  addr_t        bottom;
  twiddle_idx_t k;
  data_t        tw_im;

  assign last_cnt  = cnt == addr_t'(N_POINTS - 1);
  assign last_bfly = (stage == 2'(LOG2_N - 1)) && (bfly == 2'(N_POINTS / 2 - 1));

  // ========================================================================
  // butterfly addressing and twiddle
  // ========================================================================

  always_comb begin
    span   = addr_t'(1) << stage;
    low    = addr_t'(bfly) & (span - addr_t'(1));
    // group base is (j >> s) * 2 * span
    top    = ((addr_t'(bfly) >> stage) << (stage + 2'd1)) | low;
    bottom = top + span;
    k      = twiddle_idx_t'(low << (LOG2_N - 1 - stage));
  end

  // forward table, imaginary part negated for the inverse
  always_comb begin
    case (k)
      2'd0: begin
        bf_wr = TW_ONE;
        tw_im = '0;
      end
      2'd1: begin
        bf_wr = TW_HALF_SQRT2;
        tw_im = -TW_HALF_SQRT2;
      end
      2'd2: begin
        bf_wr = '0;
        tw_im = -TW_ONE;
      end
      default: begin
        bf_wr = -TW_HALF_SQRT2;
        tw_im = -TW_HALF_SQRT2;
      end
    endcase
  end

  assign bf_wi    = inv_q ? -tw_im : tw_im;
  assign bf_scale = scale_q[stage];

  // ========================================================================
  // strobes and buffer ports
  // ========================================================================

  assign busy        = state != st_idle;
  // load at the bit-reversed index
  assign ld_en       = (state == st_load) && in_valid;
  assign ld_addr     = {cnt[0], cnt[1], cnt[2]};
  assign ld_re       = in_re;
  assign ld_im       = in_im;
  // port a streams the result during unload
  assign rd_a_addr   = (state == st_unload) ? cnt : top;
  assign rd_b_addr   = bottom;
  assign bf_recv_val = state == st_issue;
  // write-back on the butterfly output strobe
  assign wb_en       = (state == st_wait) && bf_send_val;
  assign wb_a_addr   = top;
  assign wb_b_addr   = bottom;
  assign out_valid   = state == st_unload;
  assign out_index   = cnt;
  assign done        = (state == st_unload) && last_cnt;

  // ========================================================================
  // frame FSM
  // ========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      cnt     <= '0;
      stage   <= '0;
      bfly    <= '0;
      scale_q <= '0;
      inv_q   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            // settings fixed for the whole frame
            scale_q <= scale_mask;
            inv_q   <= inverse;
            cnt     <= '0;
            state   <= st_load;
          end
        end
        st_load: begin
          if (in_valid) begin
            cnt <= cnt + addr_t'(1);
            if (last_cnt) begin
              stage <= '0;
              bfly  <= '0;
              state <= st_issue;
            end
          end
        end
        st_issue: begin
          if (bf_recv_rdy) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (bf_send_val) begin
            if (last_bfly) begin
              cnt   <= '0;
              state <= st_unload;
            end else begin
              bfly  <= bfly + 2'd1;
              // next stage after the fourth butterfly
              if (bfly == 2'(N_POINTS / 2 - 1)) begin
                stage <= stage + 2'd1;
              end
              state <= st_issue;
            end
          end
        end
        st_unload: begin
          cnt <= cnt + addr_t'(1);
          if (last_cnt) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* source/fft_config.sv */
// ==========================================================================
// fft configuration
// per-stage scale mask and inverse flag, frozen while a frame is running
// ==========================================================================

module fft_config import fft_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        cfg_wr,
  input  stage_mask_t cfg_scale,
  input  logic        cfg_inverse,
  input  logic        busy,
  output stage_mask_t scale_mask,
  output logic        inverse
);

  logic wr_ok;

  // writes during a frame are dropped, not deferred
  assign wr_ok = cfg_wr & ~busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      scale_mask <= '0;
      inverse    <= 1'b0;
    end else if (wr_ok) begin
      // bit s halves the outputs of stage s
      scale_mask <= cfg_scale;
      // conjugate twiddles
      inverse    <= cfg_inverse;
    end
  end

endmodule

/* source/sample_buffer.sv */
// ==========================================================================
// sample buffer
// eight complex words with a load port, two combinational read ports and
// a two-word butterfly write-back port
// ==========================================================================

module sample_buffer import fft_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  ld_en,
  input  addr_t ld_addr,
  input  data_t ld_re,
  input  data_t ld_im,
  input  addr_t rd_a_addr,
  input  addr_t rd_b_addr,
  output data_t rd_a_re,
  output data_t rd_a_im,
  output data_t rd_b_re,
  output data_t rd_b_im,
  input  logic  wb_en,
  input  addr_t wb_a_addr,
  input  addr_t wb_b_addr,
  input  data_t wb_a_re,
  input  data_t wb_a_im,
  input  data_t wb_b_re,
  input  data_t wb_b_im
);

  data_t mem_re [N_POINTS];
  data_t mem_im [N_POINTS];

  // load and write-back never overlap, the controller phases keep them apart
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < N_POINTS; i++) begin
        mem_re[i] <= '0;
        mem_im[i] <= '0;
      end
    end else if (ld_en) begin
      mem_re[ld_addr] <= ld_re;
      mem_im[ld_addr] <= ld_im;
    end else if (wb_en) begin
      // top and bottom of a butterfly are always distinct words
      mem_re[wb_a_addr] <= wb_a_re;
      mem_im[wb_a_addr] <= wb_a_im;
      mem_re[wb_b_addr] <= wb_b_re;
      mem_im[wb_b_addr] <= wb_b_im;
    end
  end

  // port a feeds the butterfly top operand and the output stream
  assign rd_a_re = mem_re[rd_a_addr];
  assign rd_a_im = mem_im[rd_a_addr];
  // port b feeds the bottom operand
  assign rd_b_re = mem_re[rd_b_addr];
  assign rd_b_im = mem_im[rd_b_addr];

endmodule

/* source/butterfly.sv */
// ==========================================================================
// butterfly
// radix-2 butterfly c = a + w*b, d = a - w*b with a val/rdy input,
// optional halving of both outputs and registered results
// ==========================================================================

module butterfly import fft_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  recv_val,
  output logic  recv_rdy,
  input  data_t ar,
  input  data_t ai,
  input  data_t br,
  input  data_t bi,
  input  data_t wr,
  input  data_t wi,
  input  logic  scale,
  output logic  send_val,
  output data_t cr,
  output data_t ci,
  output data_t dr,
  output data_t di
);

  logic  accept;
  logic  busy_q;
  logic  mul_done;
  data_t tr;
  data_t ti;

  // a and scale held until the twiddle product is ready
  data_t ar_q;
  data_t ai_q;
  logic  scale_q;

  // wide sums, one cycle after mul_done
  logic sum_vld;
  sum_t c_re_s;
  sum_t c_im_s;
  sum_t d_re_s;
  sum_t d_im_s;

  // optional halving, then wrap to the sample width
  function automatic data_t halve_wrap(input sum_t s, input logic sc);
    sum_t v;
    v = sc ? (s >>> 1) : s;
    return v[DATA_W-1:0];
  endfunction

  assign recv_rdy = ~busy_q;
  assign accept   = recv_val & recv_rdy;

  complex_multiplier u_mul (
    .clk       (clk),
    .reset     (reset),
    .mul_start (accept),
    .br        (br),
    .bi        (bi),
    .wr        (wr),
    .wi        (wi),
    .mul_done  (mul_done),
    .pr        (tr),
    .pi        (ti)
  );

  // busy from the accepting edge through the send_val cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q   <= 1'b0;
      sum_vld  <= 1'b0;
      send_val <= 1'b0;
    end else begin
      sum_vld  <= mul_done;
      send_val <= sum_vld;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (send_val) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ar_q    <= ar;
      ai_q    <= ai;
      scale_q <= scale;
    end
    if (mul_done) begin
      c_re_s <= sum_t'(ar_q) + sum_t'(tr);
      c_im_s <= sum_t'(ai_q) + sum_t'(ti);
      d_re_s <= sum_t'(ar_q) - sum_t'(tr);
      d_im_s <= sum_t'(ai_q) - sum_t'(ti);
    end
    if (sum_vld) begin
      cr <= halve_wrap(c_re_s, scale_q);
      ci <= halve_wrap(c_im_s, scale_q);
      dr <= halve_wrap(d_re_s, scale_q);
      di <= halve_wrap(d_im_s, scale_q);
    end
  end

endmodule

/* source/complex_multiplier.sv */
// ==========================================================================
// complex multiplier
// sequential complex product p = b * w through one shared real multiplier,
// four cycles per product, Q2.14 result truncated toward minus infinity
// ==========================================================================

module complex_multiplier import fft_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  mul_start,
  input  data_t br,
  input  data_t bi,
  input  data_t wr,
  input  data_t wi,
  output logic  mul_done,
  output data_t pr,
  output data_t pi
);

  // operands held for the whole product
  data_t br_q;
  data_t bi_q;
  data_t wr_q;
  data_t wi_q;

  logic       active;
  logic [1:0] step;

  // shared multiplier operands and result
  data_t mul_x;
  data_t mul_y;
  acc_t  prod;

  acc_t acc_re;
  acc_t acc_im;
  // imaginary sum including the last product
  acc_t im_final;

  // product schedule
  // step 0: br*wr  step 1: bi*wi  step 2: br*wi  step 3: bi*wr
  always_comb begin
    case (step)
      2'd0: begin
        mul_x = br_q;
        mul_y = wr_q;
      end
      2'd1: begin
        mul_x = bi_q;
        mul_y = wi_q;
      end
      2'd2: begin
        mul_x = br_q;
        mul_y = wi_q;
      end
      default: begin
        mul_x = bi_q;
        mul_y = wr_q;
      end
    endcase
  end

  // signed operands, sign extended to the accumulator width
  assign prod     = mul_x * mul_y;
  assign im_final = acc_im + prod;

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      step     <= '0;
      mul_done <= 1'b0;
    end else begin
      mul_done <= 1'b0;
      if (mul_start) begin
        active <= 1'b1;
        step   <= '0;
      end else if (active) begin
        step <= step + 2'd1;
        if (step == 2'(MUL_CYCLES - 1)) begin
          active   <= 1'b0;
          mul_done <= 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (mul_start) begin
      br_q <= br;
      bi_q <= bi;
      wr_q <= wr;
      wi_q <= wi;
    end
    if (active) begin
      case (step)
        2'd0: acc_re <= prod;
        2'd1: acc_re <= acc_re - prod;
        2'd2: acc_im <= prod;
        default: begin
          // arithmetic shift by FRAC_W then keep the low DATA_W bits
          pr <= acc_re[FRAC_W +: DATA_W];
          pi <= im_final[FRAC_W +: DATA_W];
        end
      endcase
    end
  end

endmodule

/* source/fft_pkg.sv */
// ==========================================================================
// fft package
// widths, sample types, twiddle constants and controller states for the
// iterative 8-point radix-2 DIT FFT engine
// ==========================================================================

package fft_pkg;

  // ========================================================================
  // sizes
  // ========================================================================

  // samples are Q2.14
  localparam int DATA_W   = 16;
  localparam int FRAC_W   = 14;
  localparam int N_POINTS = 8;
  localparam int LOG2_N   = 3;

  // full product sum width, two 32-bit products plus headroom
  localparam int ACC_W = 2 * DATA_W + 2;
  // butterfly sum width, one guard bit
  localparam int SUM_W = DATA_W + 1;

  // multiplier latency in edges, one real product per cycle
  localparam int MUL_CYCLES = 4;

  // ========================================================================
  // types
  // ========================================================================

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic signed [SUM_W-1:0]  sum_t;
  typedef logic [LOG2_N-1:0]        addr_t;
  typedef logic [LOG2_N-2:0]        twiddle_idx_t;
  typedef logic [LOG2_N-1:0]        stage_mask_t;

  // twiddle magnitudes, W8^k = cos - j*sin for the forward transform
  localparam data_t TW_ONE        = 16'sd16384;
  localparam data_t TW_HALF_SQRT2 = 16'sd11585;

  // frame sequencing
  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_issue,
    st_wait,
    st_unload
  } ctrl_state_t;

endpackage
